// File: include/axi_demux_macros.svh
// Build-time parameters of the AXI demultiplexer
// Port count, bus widths and the outstanding-transaction limit

`ifndef AXI_DEMUX_MACROS_SVH
`define AXI_DEMUX_MACROS_SVH

// ------------------------------
// Topology
// ------------------------------

// Number of master ports behind the demux
`define AXI_NUM_PORTS 4

// ------------------------------
// Bus widths
// ------------------------------

// Full transaction ID width
`define AXI_ID_WIDTH 4
// Low ID bits that index the ordering tables
`define AXI_LOOK_BITS 2
// Address and data widths
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32

// ------------------------------
// Limits
// ------------------------------

// Max outstanding transactions per ID and max open W bursts
`define AXI_MAX_TRANS 7

`endif

// File: rtl/axi_demux_pkg.sv
// Types shared by the AXI demultiplexer
// Channel payloads, request and response bundles, select and counter types

`include "axi_demux_macros.svh"

package axi_demux_pkg;

    // ------------------------------
    // Scalar types
    // ------------------------------

    // Master port index
    typedef logic [$clog2(`AXI_NUM_PORTS)-1:0] sel_t;
    // Outstanding counter, wide enough for the max count
    typedef logic [$clog2(`AXI_MAX_TRANS + 1)-1:0] cnt_t;

    typedef logic [`AXI_ID_WIDTH-1:0]   id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [7:0]                 len_t;
    typedef logic [1:0]                 resp_t;

    // ------------------------------
    // Channel payloads
    // ------------------------------

    // Address request, used for both AW and AR
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } aw_chan_t;

    // AR has the same layout as AW
    typedef aw_chan_t ar_chan_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_chan_t;

    // ------------------------------
    // Bundles
    // ------------------------------

    // Everything flowing from master to slave
    typedef struct packed {
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     b_ready;
        ar_chan_t ar;
        logic     ar_valid;
        logic     r_ready;
    } axi_req_t;

    // Everything flowing back from slave to master
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        b_chan_t b;
        logic    b_valid;
        logic    ar_ready;
        r_chan_t r;
        logic    r_valid;
    } axi_resp_t;

endpackage

// File: rtl/axi_demux_id_table.sv
// ID ordering table for the AXI demux
// Counts in-flight transactions per ID slot and remembers their target port

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux_id_table
    import axi_demux_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    // Lookup of the ID shown on the slave port
    input  id_t  lookup_id_i,
    output sel_t lookup_sel_o,
    output logic occupied_o,
    output logic full_o,
    // Request routed to a master port
    input  logic push_i,
    input  id_t  push_id_i,
    input  sel_t push_sel_i,
    // Closing response seen on the slave port
    input  logic pop_i,
    input  id_t  pop_id_i
);

    localparam int unsigned NUM_ENTRIES = 2 ** `AXI_LOOK_BITS;

    typedef logic [`AXI_LOOK_BITS-1:0] idx_t;

    // One counter and one port per slot
    cnt_t cnt_q [NUM_ENTRIES];
    sel_t sel_q [NUM_ENTRIES];

    idx_t lookup_idx;
    idx_t push_idx;
    idx_t pop_idx;
    logic [NUM_ENTRIES-1:0] at_max;

    // Only the low ID bits select a slot, aliasing IDs share it
    assign lookup_idx = lookup_id_i[`AXI_LOOK_BITS-1:0];
    assign push_idx   = push_id_i[`AXI_LOOK_BITS-1:0];
    assign pop_idx    = pop_id_i[`AXI_LOOK_BITS-1:0];

    // ------------------------------
    // Counters
    // ------------------------------

    // Push and pop on the same slot cancel out
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (push_i && (push_idx == idx_t'(i)) &&
                    !(pop_i && (pop_idx == idx_t'(i)))) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end else if (pop_i && (pop_idx == idx_t'(i)) &&
                             !(push_i && (push_idx == idx_t'(i)))) begin
                    cnt_q[i] <= cnt_q[i] - 1'b1;
                end
            end
        end
    end

    // Target port of the slot, valid while its counter is nonzero
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sel_q[push_idx] <= push_sel_i;
        end
    end

    // ------------------------------
    // Status
    // ------------------------------

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            at_max[i] = (cnt_q[i] == cnt_t'(`AXI_MAX_TRANS));
        end
    end

    // Any saturated slot blocks new pushes
    assign full_o       = |at_max;
    assign occupied_o   = (cnt_q[lookup_idx] != '0);
    assign lookup_sel_o = sel_q[lookup_idx];

endmodule

// File: rtl/axi_demux_write_ctrl.sv
// Write path control of the AXI demux
// AW admission with valid lock, open W burst counter and W routing

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux_write_ctrl
    import axi_demux_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    // AW from the slave port
    input  logic aw_valid_i,
    input  id_t  aw_id_i,
    input  sel_t aw_select_i,
    // Ready of the master selected by aw_select_i
    input  logic aw_ready_i,
    output logic aw_valid_o,
    output logic aw_ready_o,
    // W from the slave port
    input  logic w_valid_i,
    input  logic w_last_i,
    // Ready of the master selected by w_sel_o
    input  logic w_ready_i,
    output sel_t w_sel_o,
    output logic w_active_o,
    output logic w_ready_o,
    // B transfer on the slave port
    input  id_t  b_fire_id_i,
    input  logic b_fire_i
);

    sel_t lookup_sel;
    logic occupied;
    logic id_full;

    // Lock keeps valid high once shown without ready
    logic lock_q;
    logic admissible;
    logic aw_first;

    // Open W bursts and the port they all target
    cnt_t w_open_q;
    sel_t w_sel_q;
    logic w_any_open;
    logic w_close;

    // ------------------------------
    // ID ordering
    // ------------------------------

    // Pushed when the AW is first shown, the lock guarantees its transfer
    axi_demux_id_table aw_table (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_id_i  (aw_id_i),
        .lookup_sel_o (lookup_sel),
        .occupied_o   (occupied),
        .full_o       (id_full),
        .push_i       (aw_first),
        .push_id_i    (aw_id_i),
        .push_sel_i   (aw_select_i),
        .pop_i        (b_fire_i),
        .pop_id_i     (b_fire_id_i)
    );

    // ------------------------------
    // AW admission
    // ------------------------------

    assign w_any_open = (w_open_q != '0);

    // W bursts must stay in AW order, so a new port waits for open bursts to drain
    assign admissible = !id_full &&
                        (w_open_q != cnt_t'(`AXI_MAX_TRANS)) &&
                        (!w_any_open || (w_sel_q == aw_select_i)) &&
                        (!occupied || (lookup_sel == aw_select_i));

    assign aw_first   = aw_valid_i && !lock_q && admissible;
    assign aw_valid_o = lock_q || aw_first;
    assign aw_ready_o = aw_valid_o && aw_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= aw_valid_o && !aw_ready_i;
        end
    end

    // ------------------------------
    // W routing
    // ------------------------------

    // A burst may start in the same cycle its AW is first shown
    assign w_active_o = aw_first || w_any_open;
    assign w_sel_o    = w_any_open ? w_sel_q : aw_select_i;
    assign w_ready_o  = w_active_o && w_ready_i;
    assign w_close    = w_valid_i && w_ready_o && w_last_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            w_open_q <= '0;
        end else if (aw_first && !w_close) begin
            w_open_q <= w_open_q + 1'b1;
        end else if (w_close && !aw_first) begin
            w_open_q <= w_open_q - 1'b1;
        end
    end

    // All open bursts share one port, the latest AW refreshes it
    always_ff @(posedge clk_i) begin
        if (aw_first) begin
            w_sel_q <= aw_select_i;
        end
    end

endmodule

// File: rtl/axi_demux_read_ctrl.sv
// Read path control of the AXI demux
// AR admission by ID ordering, valid lock and read ID bookkeeping

`timescale 1ns/1ps

module axi_demux_read_ctrl
    import axi_demux_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    // AR from the slave port
    input  logic ar_valid_i,
    input  id_t  ar_id_i,
    input  sel_t ar_select_i,
    // Ready of the master selected by ar_select_i
    input  logic ar_ready_i,
    output logic ar_valid_o,
    output logic ar_ready_o,
    // Last R beat accepted on the slave port
    input  id_t  r_fire_id_i,
    input  logic r_fire_i
);

    sel_t lookup_sel;
    logic occupied;
    logic id_full;
    logic lock_q;
    logic admissible;
    logic ar_push;

    // Pushed on the AR transfer, popped on the last R beat
    axi_demux_id_table ar_table (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_id_i  (ar_id_i),
        .lookup_sel_o (lookup_sel),
        .occupied_o   (occupied),
        .full_o       (id_full),
        .push_i       (ar_push),
        .push_id_i    (ar_id_i),
        .push_sel_i   (ar_select_i),
        .pop_i        (r_fire_i),
        .pop_id_i     (r_fire_id_i)
    );

    // Same ID to another port would reorder R beats
    assign admissible = !id_full && (!occupied || (lookup_sel == ar_select_i));

    assign ar_valid_o = lock_q || (ar_valid_i && admissible);
    assign ar_ready_o = ar_valid_o && ar_ready_i;
    assign ar_push    = ar_ready_o;

    // Hold valid until the selected master takes it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= ar_valid_o && !ar_ready_i;
        end
    end

endmodule

// File: rtl/axi_demux_resp_arb.sv
// Round-robin response arbiter for the AXI demux
// Merges one response channel from all master ports, grant held until ready

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux_resp_arb
    import axi_demux_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    // Per-port responses
    input  logic     [`AXI_NUM_PORTS-1:0]     valid_i,
    input  payload_t [`AXI_NUM_PORTS-1:0]     payload_i,
    output logic     [`AXI_NUM_PORTS-1:0]     ready_o,
    // Merged response toward the slave port
    output logic                              valid_o,
    output payload_t                          payload_o,
    input  logic                              ready_i
);

    localparam int unsigned NUM_PORTS = `AXI_NUM_PORTS;

    // First port looked at in the next free arbitration
    sel_t ptr_q;
    sel_t gnt_idx_q;
    logic lock_q;
    sel_t gnt_idx;
    logic found;

    // ------------------------------
    // Grant selection
    // ------------------------------

    always_comb begin : rr_pick
        sel_t cand;
        found   = 1'b0;
        gnt_idx = ptr_q;
        // Scan from the pointer and wrap around
        for (int k = 0; k < NUM_PORTS; k++) begin
            cand = sel_t'((int'(ptr_q) + k) % NUM_PORTS);
            if (!found && valid_i[cand]) begin
                found   = 1'b1;
                gnt_idx = cand;
            end
        end
        // A stalled response keeps its grant
        if (lock_q) begin
            gnt_idx = gnt_idx_q;
            found   = valid_i[gnt_idx_q];
        end
    end

    assign valid_o   = found;
    assign payload_o = found ? payload_i[gnt_idx] : '0;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            ready_o[i] = found && ready_i && (gnt_idx == sel_t'(i));
        end
    end

    // ------------------------------
    // State
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q     <= '0;
            gnt_idx_q <= '0;
            lock_q    <= 1'b0;
        end else begin
            lock_q    <= valid_o && !ready_i;
            gnt_idx_q <= gnt_idx;
            // Next search starts just after the port that was served
            if (valid_o && ready_i) begin
                ptr_q <= (gnt_idx == sel_t'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

endmodule

// File: rtl/axi_demux.sv
// AXI4 demultiplexer top level
// One slave port to AXI_NUM_PORTS master ports, B and R merged round-robin

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux
    import axi_demux_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Slave port
    input  axi_req_t                            slv_req_i,
    input  sel_t                                aw_select_i,
    input  sel_t                                ar_select_i,
    output axi_resp_t                           slv_resp_o,
    // Master ports
    output axi_req_t  [`AXI_NUM_PORTS-1:0]      mst_req_o,
    input  axi_resp_t [`AXI_NUM_PORTS-1:0]      mst_resp_i
);

    logic aw_valid;
    logic ar_valid;
    sel_t w_sel;
    logic w_active;
    logic b_fire;
    logic r_fire;

    logic    [`AXI_NUM_PORTS-1:0] b_valids;
    logic    [`AXI_NUM_PORTS-1:0] b_readies;
    b_chan_t [`AXI_NUM_PORTS-1:0] b_chans;
    logic    [`AXI_NUM_PORTS-1:0] r_valids;
    logic    [`AXI_NUM_PORTS-1:0] r_readies;
    r_chan_t [`AXI_NUM_PORTS-1:0] r_chans;

    // Slave-side handshakes, R only closes a burst on last
    assign b_fire = slv_resp_o.b_valid && slv_req_i.b_ready;
    assign r_fire = slv_resp_o.r_valid && slv_req_i.r_ready && slv_resp_o.r.last;

    axi_demux_write_ctrl write_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .aw_valid_i  (slv_req_i.aw_valid),
        .aw_id_i     (slv_req_i.aw.id),
        .aw_select_i (aw_select_i),
        .aw_ready_i  (mst_resp_i[aw_select_i].aw_ready),
        .aw_valid_o  (aw_valid),
        .aw_ready_o  (slv_resp_o.aw_ready),
        .w_valid_i   (slv_req_i.w_valid),
        .w_last_i    (slv_req_i.w.last),
        .w_ready_i   (mst_resp_i[w_sel].w_ready),
        .w_sel_o     (w_sel),
        .w_active_o  (w_active),
        .w_ready_o   (slv_resp_o.w_ready),
        .b_fire_id_i (slv_resp_o.b.id),
        .b_fire_i    (b_fire)
    );

    axi_demux_read_ctrl read_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ar_valid_i  (slv_req_i.ar_valid),
        .ar_id_i     (slv_req_i.ar.id),
        .ar_select_i (ar_select_i),
        .ar_ready_i  (mst_resp_i[ar_select_i].ar_ready),
        .ar_valid_o  (ar_valid),
        .ar_ready_o  (slv_resp_o.ar_ready),
        .r_fire_id_i (slv_resp_o.r.id),
        .r_fire_i    (r_fire)
    );

    axi_demux_resp_arb #(.payload_t(b_chan_t)) b_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (b_valids),
        .payload_i (b_chans),
        .ready_o   (b_readies),
        .valid_o   (slv_resp_o.b_valid),
        .payload_o (slv_resp_o.b),
        .ready_i   (slv_req_i.b_ready)
    );

    axi_demux_resp_arb #(.payload_t(r_chan_t)) r_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (r_valids),
        .payload_i (r_chans),
        .ready_o   (r_readies),
        .valid_o   (slv_resp_o.r_valid),
        .payload_o (slv_resp_o.r),
        .ready_i   (slv_req_i.r_ready)
    );

    // ------------------------------
    // Per-port fan-out
    // ------------------------------

    // Payloads go to every port, valids only to the selected one
    for (genvar i = 0; i < `AXI_NUM_PORTS; i++) begin : gen_port
        assign mst_req_o[i].aw       = slv_req_i.aw;
        assign mst_req_o[i].aw_valid = aw_valid && (aw_select_i == sel_t'(i));
        assign mst_req_o[i].w        = slv_req_i.w;
        assign mst_req_o[i].w_valid  = slv_req_i.w_valid && w_active && (w_sel == sel_t'(i));
        assign mst_req_o[i].b_ready  = b_readies[i];
        assign mst_req_o[i].ar       = slv_req_i.ar;
        assign mst_req_o[i].ar_valid = ar_valid && (ar_select_i == sel_t'(i));
        assign mst_req_o[i].r_ready  = r_readies[i];

        // Responses into the arbiters
        assign b_valids[i] = mst_resp_i[i].b_valid;
        assign b_chans[i]  = mst_resp_i[i].b;
        assign r_valids[i] = mst_resp_i[i].r_valid;
        assign r_chans[i]  = mst_resp_i[i].r;
    end

endmodule

// File: verification/axi_demux_checker.sv
// Handshake stability assertions for the AXI demux
// Master AW/AR and slave B/R payloads hold until ready

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux_checker
    import axi_demux_pkg::*;
(
    input logic                             clk_i,
    input logic                             rst_n_i,
    input axi_req_t                         slv_req_i,
    input axi_resp_t                        slv_resp_i,
    input axi_req_t  [`AXI_NUM_PORTS-1:0]   mst_req_i,
    input axi_resp_t [`AXI_NUM_PORTS-1:0]   mst_resp_i
);

    // ------------------------------
    // Master request side
    // ------------------------------
    for (genvar p = 0; p < `AXI_NUM_PORTS; p++) begin : gen_port
        aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            mst_req_i[p].aw_valid && !mst_resp_i[p].aw_ready |=>
            mst_req_i[p].aw_valid && $stable(mst_req_i[p].aw))
            else $error("AW on port %0d dropped or changed before ready", p);

        ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            mst_req_i[p].ar_valid && !mst_resp_i[p].ar_ready |=>
            mst_req_i[p].ar_valid && $stable(mst_req_i[p].ar))
            else $error("AR on port %0d dropped or changed before ready", p);
    end

    // ------------------------------
    // Slave response side
    // ------------------------------
    b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        slv_resp_i.b_valid && !slv_req_i.b_ready |=>
        slv_resp_i.b_valid && $stable(slv_resp_i.b))
        else $error("Slave B dropped or changed before ready");

    r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        slv_resp_i.r_valid && !slv_req_i.r_ready |=>
        slv_resp_i.r_valid && $stable(slv_resp_i.r))
        else $error("Slave R dropped or changed before ready");

endmodule

// File: verification/axi_demux_tb.sv
// Testbench for the AXI demux
// Golden-file driven slave port, in-order master port models, scoreboard checks

`timescale 1ns/1ps

`include "axi_demux_macros.svh"

module axi_demux_tb
    import axi_demux_pkg::*;
();

    localparam int NP = `AXI_NUM_PORTS;

    logic clk_i;
    logic rst_n_i;
    axi_req_t  slv_req_drv;
    axi_req_t  slv_req;
    logic      slv_b_ready;
    logic      slv_r_ready;
    sel_t      aw_sel;
    sel_t      ar_sel;
    axi_resp_t slv_resp;
    axi_req_t  [NP-1:0] mst_req;
    axi_resp_t [NP-1:0] mst_resp;

    logic [35:0] golden [32];
    int n_lines, n_wr, n_rd, b_cnt, r_cnt, cycles;

    // Current request on the slave port and its golden expectation
    logic [3:0]  cur_aw_port, cur_ar_port, cur_w_port;
    logic [7:0]  cur_ar_len;
    logic [11:0] cur_aw_exp, cur_ar_exp;
    logic [31:0] exp_w_data;
    logic        exp_w_last;

    // Port model queues of accepted AW ids, pending B ids and pending reads as {id, len}
    logic [3:0]  awq [NP][$];
    logic [3:0]  bq  [NP][$];
    logic [11:0] rq  [NP][$];
    int          rbeat [NP];
    // Slave scoreboard per ID with B resp and reads as {port, len, data base}
    logic [1:0]  wexp [16][$];
    logic [23:0] rexp [16][$];
    int          sbeat [16];

    always_comb begin
        slv_req         = slv_req_drv;
        slv_req.b_ready = slv_b_ready;
        slv_req.r_ready = slv_r_ready;
    end

    axi_demux axi_demux_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .slv_req_i   (slv_req),
        .aw_select_i (aw_sel),
        .ar_select_i (ar_sel),
        .slv_resp_o  (slv_resp),
        .mst_req_o   (mst_req),
        .mst_resp_i  (mst_resp)
    );

    bind axi_demux axi_demux_checker checker_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .slv_req_i  (slv_req_i),
        .slv_resp_i (slv_resp_o),
        .mst_req_i  (mst_req_o),
        .mst_resp_i (mst_resp_i)
    );

    always #10 clk_i = ~clk_i;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
        fail_run($sformatf("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp));
    endtask

    // ------------------------------
    // Port models driven after the edge
    // ------------------------------
    // Readies toggle freely in reset, no valid is up then
    always @(posedge clk_i) begin
        #1;
        slv_b_ready = ($urandom_range(0, 3) != 0);
        slv_r_ready = ($urandom_range(0, 3) != 0);
        for (int p = 0; p < NP; p++) begin
            mst_resp[p]          = '0;
            mst_resp[p].aw_ready = ($urandom_range(0, 2) != 0);
            mst_resp[p].w_ready  = ($urandom_range(0, 2) != 0);
            mst_resp[p].ar_ready = ($urandom_range(0, 2) != 0);
            if (bq[p].size() != 0) begin
                mst_resp[p].b_valid = 1'b1;
                mst_resp[p].b.id    = bq[p][0];
                mst_resp[p].b.resp  = 2'(p % 4);
            end
            if (rq[p].size() != 0) begin
                mst_resp[p].r_valid = 1'b1;
                mst_resp[p].r.id    = rq[p][0][11:8];
                // Port model data is port * 256 + id * 16 + beat
                mst_resp[p].r.data  = 32'(p * 256) + 32'(rq[p][0][11:8]) * 16 + 32'(rbeat[p]);
                mst_resp[p].r.last  = (rbeat[p] == int'(rq[p][0][7:0]));
            end
        end
    end

    // ------------------------------
    // Monitor sampled on the falling edge
    // ------------------------------
    always @(negedge clk_i) begin
        int id;
        logic [23:0] e;
        if (rst_n_i) begin
            if (slv_resp.b_valid && slv_req.b_ready) begin
                id = int'(slv_resp.b.id);
                assert (wexp[id].size() != 0)
                    else fail_run("B response for an ID with no open write");
                assert (slv_resp.b.resp == wexp[id][0])
                    else report_value("slv_resp_o.b.resp", slv_resp.b.resp, wexp[id][0]);
                void'(wexp[id].pop_front());
                b_cnt++;
            end
            if (slv_resp.r_valid && slv_req.r_ready) begin
                id = int'(slv_resp.r.id);
                assert (rexp[id].size() != 0)
                    else fail_run("R beat for an ID with no open read");
                e = rexp[id][0];
                assert (slv_resp.r.data == 32'(e[11:0]) + 32'(sbeat[id]))
                    else report_value("slv_resp_o.r.data", slv_resp.r.data,
                                      32'(e[11:0]) + 32'(sbeat[id]));
                assert (slv_resp.r.last == (sbeat[id] == int'(e[19:12])))
                    else report_value("slv_resp_o.r.last", slv_resp.r.last,
                                      sbeat[id] == int'(e[19:12]));
                if (slv_resp.r.last) begin
                    void'(rexp[id].pop_front());
                    sbeat[id] = 0;
                    r_cnt++;
                end else begin
                    sbeat[id]++;
                end
            end
            for (int p = 0; p < NP; p++) begin
                if (mst_req[p].aw_valid) begin
                    assert (slv_req.aw_valid && 4'(p) == cur_aw_port)
                        else report_value("mst_req_o.aw_valid port", p, cur_aw_port);
                    assert (mst_req[p].aw == slv_req.aw)
                        else report_value("mst_req_o.aw", mst_req[p].aw, slv_req.aw);
                    if (mst_resp[p].aw_ready) begin
                        awq[p].push_back(mst_req[p].aw.id);
                        wexp[mst_req[p].aw.id].push_back(cur_aw_exp[1:0]);
                    end
                end
                if (mst_req[p].w_valid) begin
                    assert (slv_req.w_valid && 4'(p) == cur_w_port)
                        else report_value("mst_req_o.w_valid port", p, cur_w_port);
                    if (mst_resp[p].w_ready) begin
                        assert (mst_req[p].w.data == exp_w_data)
                            else report_value("mst_req_o.w.data", mst_req[p].w.data, exp_w_data);
                        assert (mst_req[p].w.last == exp_w_last)
                            else report_value("mst_req_o.w.last", mst_req[p].w.last, exp_w_last);
                        if (mst_req[p].w.last) begin
                            bq[p].push_back(awq[p].pop_front());
                        end
                    end
                end
                if (mst_resp[p].b_valid && mst_req[p].b_ready) begin
                    void'(bq[p].pop_front());
                end
                if (mst_resp[p].r_valid && mst_req[p].r_ready) begin
                    if (mst_resp[p].r.last) begin
                        void'(rq[p].pop_front());
                        rbeat[p] = 0;
                    end else begin
                        rbeat[p]++;
                    end
                end
                if (mst_req[p].ar_valid) begin
                    assert (slv_req.ar_valid && 4'(p) == cur_ar_port)
                        else report_value("mst_req_o.ar_valid port", p, cur_ar_port);
                    assert (mst_req[p].ar == slv_req.ar)
                        else report_value("mst_req_o.ar", mst_req[p].ar, slv_req.ar);
                    id = int'(mst_req[p].ar.id);
                    // Same ID toward another port must wait for the last R beat
                    if (rexp[id].size() != 0) begin
                        assert (rexp[id][0][23:20] == 4'(p))
                            else fail_run("Read reached a new port while its ID was still open");
                    end
                    if (mst_resp[p].ar_ready) begin
                        rexp[id].push_back({4'(p), cur_ar_len, cur_ar_exp});
                        rq[p].push_back({mst_req[p].ar.id, mst_req[p].ar.len});
                    end
                end
            end
        end
    end

    // Timeout scaled by the number of golden transactions
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 200 * n_lines + 8) begin
            fail_run("Timeout waiting for all responses");
        end
    end

    // ------------------------------
    // Slave port driver
    // ------------------------------
    task automatic send_write(logic [35:0] g);
        cur_aw_port = g[15:12];
        cur_aw_exp  = g[11:0];
        slv_req_drv.aw.id   = g[31:28];
        slv_req_drv.aw.addr = g[31:16];
        slv_req_drv.aw.len  = g[23:16];
        aw_sel              = sel_t'(g[27:24]);
        slv_req_drv.aw_valid = 1'b1;
        do @(negedge clk_i); while (!slv_resp.aw_ready);
        @(posedge clk_i);
        #1;
        slv_req_drv.aw_valid = 1'b0;
        cur_w_port = g[15:12];
        for (int beat = 0; beat <= int'(g[23:16]); beat++) begin
            exp_w_data = {g[31:16], 8'h0, 8'(beat)};
            exp_w_last = (beat == int'(g[23:16]));
            slv_req_drv.w.data  = exp_w_data;
            slv_req_drv.w.last  = exp_w_last;
            slv_req_drv.w_valid = 1'b1;
            do @(negedge clk_i); while (!slv_resp.w_ready);
            @(posedge clk_i);
            #1;
        end
        slv_req_drv.w_valid = 1'b0;
    endtask

    task automatic send_read(logic [35:0] g);
        cur_ar_port = g[15:12];
        cur_ar_len  = g[23:16];
        cur_ar_exp  = g[11:0];
        slv_req_drv.ar.id   = g[31:28];
        slv_req_drv.ar.addr = g[31:16];
        slv_req_drv.ar.len  = g[23:16];
        ar_sel              = sel_t'(g[27:24]);
        slv_req_drv.ar_valid = 1'b1;
        do @(negedge clk_i); while (!slv_resp.ar_ready);
        @(posedge clk_i);
        #1;
        slv_req_drv.ar_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h8bfd));
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        slv_req_drv = '0;
        slv_b_ready = 1'b0;
        slv_r_ready = 1'b0;
        aw_sel = '0;
        ar_sel = '0;
        mst_resp = '0;
        cur_aw_port = 4'hf;
        cur_ar_port = 4'hf;
        cur_w_port = 4'hf;
        $readmemh("verification/axi_demux_golden.txt", golden);
        while (n_lines < 32 && !$isunknown(golden[n_lines])) begin
            if (golden[n_lines][35:32] == 4'h0) n_wr++;
            else n_rd++;
            n_lines++;
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            if (golden[i][35:32] == 4'h0) send_write(golden[i]);
            else send_read(golden[i]);
        end
        // Every failing check stops the run, so reaching here means all passed
        while (!(b_cnt == n_wr && r_cnt == n_rd)) @(negedge clk_i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verification/axi_demux_golden.txt
// Columns: kind(0 write, 1 read) _ id _ select _ len _ expected port _ expected value
// Expected value is the B resp for a write and the first R data beat for a read
0_3_1_01_1_001
0_3_1_00_1_001
0_5_2_02_2_002
1_2_1_01_1_120
1_2_3_00_3_320
0_3_0_00_0_000
1_7_0_03_0_070
1_6_2_01_2_260
0_1_3_03_3_003
1_2_2_02_2_220
0_9_2_00_2_002
1_0_3_00_3_300
0_6_1_01_1_001
1_f_1_01_1_1f0

// File: axi_demux.f
+incdir+include
rtl/axi_demux_pkg.sv
rtl/axi_demux_id_table.sv
rtl/axi_demux_write_ctrl.sv
rtl/axi_demux_read_ctrl.sv
rtl/axi_demux_resp_arb.sv
rtl/axi_demux.sv
verification/axi_demux_checker.sv
verification/axi_demux_tb.sv

// File: Makefile
# Verilator flow for the AXI demux

FILELIST := axi_demux.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f $(FILELIST) --top-module axi_demux_tb

obj_dir/Vaxi_demux_tb: $(FILELIST)
	verilator --binary --timing --assert -f $(FILELIST) \
		--top-module axi_demux_tb -o Vaxi_demux_tb

sim: obj_dir/Vaxi_demux_tb
	./obj_dir/Vaxi_demux_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
